/* hdl/baudGen.sv */
/*
 * oversampling tick generator, one tick every baudDivisor clocks
 */
`timescale 1ns/1ps
`default_nettype none

module baudGen (
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	uartCfgPkg::baudCntT divCnt;	// free running divider

	// tick registered so the first pulse lands 4 clocks after reset
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divCnt <= '0;
			sTick  <= 1'b0;
		end
		else
		begin
			sTick <= (divCnt == uartCfgPkg::baudLast);	// wrap point
			if (divCnt == uartCfgPkg::baudLast)
				divCnt <= '0;
			else
				divCnt <= divCnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hdl/byteFifo.sv */
/*
 * 16-entry byte queue, head visible without a pop
 */
`timescale 1ns/1ps
`default_nettype none

module byteFifo (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  uartCfgPkg::byteT pushData,
	input  logic pop,
	output uartCfgPkg::byteT popData,
	output logic valid,
	output logic full
);

	uartCfgPkg::byteT mem [uartCfgPkg::fifoDepth];	// storage
	logic [uartCfgPkg::fifoAddrLen-1:0] wrPtr;
	logic [uartCfgPkg::fifoAddrLen-1:0] rdPtr;
	uartCfgPkg::fifoCntT count;	// occupancy, 0..16

	// storage write
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	// pointers wrap naturally at 16
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	assign popData = mem[rdPtr];	// head byte
	assign valid   = (count != '0);
	assign full    = (count == uartCfgPkg::fifoCntT'(uartCfgPkg::fifoDepth));

	// writers upstream keep these by credits and valid gating
	assert property (@(posedge clk) disable iff (reset) full |-> !push);
	assert property (@(posedge clk) disable iff (reset) !valid |-> !pop);

endmodule

`default_nettype wire

/* hdl/uartBusPkg.sv */
/*
 * packed structs at the uart edges: host transmit request, receive delivery,
 * receiver end-of-frame event and the host status word
 */
`default_nettype none

package uartBusPkg;

	// host write into the transmit queue, 9 bits
	typedef struct packed {
		logic push;
		uartCfgPkg::byteT data;
	} txReqT;

	// one delivered byte, 9 bits
	typedef struct packed {
		logic valid;
		uartCfgPkg::byteT data;
	} rxRespT;

	// receiver report at the middle of each stop bit, 10 bits
	typedef struct packed {
		logic valid;
		logic frameErr;	// stop bit read low
		uartCfgPkg::byteT data;
	} rxEventT;

	// status word, msb first here, txEmpty is bit 0
	typedef struct packed {
		logic spare;	// always 0
		logic frameErr;	// sticky
		logic overrun;	// sticky
		logic txBusy;
		logic rxFull;
		logic rxEmpty;
		logic txFull;
		logic txEmpty;
	} statusWordT;

endpackage

`default_nettype wire

/* hdl/uartCfgPkg.sv */
/*
 * uart configuration constants: frame format, tick rates, queue depths
 * and vector types for the widths that carry a meaning
 */
`default_nettype none

package uartCfgPkg;

	//////////////////////////////////////////////////////////////////////
	// frame and timing
	localparam int dataBits    = 8;	// data bits per frame
	localparam int sbTick      = 16;	// ticks in the stop bit
	localparam int overSample  = 16;	// ticks per bit
	localparam int baudDivisor = 4;	// clk cycles per tick, 64 cycles per bit

	// queues and credits
	localparam int fifoDepth   = 16;
	localparam int fifoAddrLen = 4;
	localparam int creditMax   = 16;	// most receive credits held at once

	//////////////////////////////////////////////////////////////////////
	typedef logic [dataBits-1:0] byteT;
	typedef logic [3:0] tickCntT;	// tick within a bit
	typedef logic [2:0] bitCntT;	// data bit index
	typedef logic [4:0] fifoCntT;	// 0..16 entries
	typedef logic [4:0] creditCntT;	// 0..16 credits
	typedef logic [$clog2(baudDivisor)-1:0] baudCntT;

	// derived compare points
	localparam tickCntT midTick  = tickCntT'(overSample / 2 - 1);	// middle of start bit
	localparam tickCntT lastTick = tickCntT'(overSample - 1);
	localparam tickCntT stopTick = tickCntT'(sbTick - 1);
	localparam bitCntT  lastBit  = bitCntT'(dataBits - 1);
	localparam baudCntT baudLast = baudCntT'(baudDivisor - 1);

endpackage

`default_nettype wire

/* hdl/uartHostPort.sv */
/*
 * host side of the uart: tx credit return, rx push/drop decision,
 * credit-gated rx delivery and the status word with sticky error bits
 */
`timescale 1ns/1ps
`default_nettype none

module uartHostPort (
	input  logic clk,
	input  logic reset,
	input  logic txDoneTick,
	input  uartBusPkg::rxEventT rxEvent,
	input  logic txValid,
	input  logic txFull,
	input  logic rxValid,
	input  logic rxFull,
	input  uartCfgPkg::byteT rxData,	// rx queue head
	input  logic txBusy,
	input  logic rxCreditGrant,
	input  logic statusRead,
	output logic rxPush,
	output logic rxPop,
	output logic txCreditRet,
	output uartBusPkg::rxRespT rxResp,
	output uartBusPkg::statusWordT status
);

	uartCfgPkg::creditCntT credits;	// receive credits held
	logic evGood;
	logic setOverrun;
	logic setFrameErr;
	logic respValid;
	uartCfgPkg::byteT respData;

	//////////////////////////////////////////////////////////////////////
	// receive decisions, all same cycle as the event
	assign evGood      = rxEvent.valid & ~rxEvent.frameErr;
	assign rxPush      = evGood & ~rxFull;
	assign setOverrun  = evGood & rxFull;	// no room, byte lost
	assign setFrameErr = rxEvent.valid & rxEvent.frameErr;	// byte dropped
	assign rxPop       = rxValid & (credits != '0);	// one per cycle

	// grant and delivery together leave the count alone
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			credits <= '0;
		else if (rxCreditGrant && !rxPop)
			credits <= credits + 1'b1;
		else if (!rxCreditGrant && rxPop)
			credits <= credits - 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// delivery, credit return and status, one cycle behind
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			respValid      <= 1'b0;
			txCreditRet    <= 1'b0;
			status         <= '0;
			status.txEmpty <= 1'b1;	// both queues start empty
			status.rxEmpty <= 1'b1;
		end
		else
		begin
			respValid       <= rxPop;
			txCreditRet     <= txDoneTick;	// byte left the tx queue
			status.txEmpty  <= ~txValid;
			status.txFull   <= txFull;
			status.rxEmpty  <= ~rxValid;
			status.rxFull   <= rxFull;
			status.txBusy   <= txBusy;
			status.overrun  <= setOverrun | (status.overrun & ~statusRead);	// new error wins
			status.frameErr <= setFrameErr | (status.frameErr & ~statusRead);
			status.spare    <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rxPop)
			respData <= rxData;
	end

	assign rxResp = {respValid, respData};

	// host must not grant past creditMax outstanding
	assert property (@(posedge clk) disable iff (reset)
		credits <= uartCfgPkg::creditCntT'(uartCfgPkg::creditMax));

endmodule

`default_nettype wire

/* hdl/uartPeriph.sv */
/*
 * uart peripheral top: tick generator, tx and rx queues,
 * serializer, deserializer and host port
 */
`timescale 1ns/1ps
`default_nettype none

module uartPeriph (
	input  logic clk,
	input  logic reset,
	input  uartBusPkg::txReqT txReq,
	input  logic rxCreditGrant,
	input  logic statusRead,
	output logic txCreditRet,
	output uartBusPkg::rxRespT rxResp,
	output uartBusPkg::statusWordT status,
	output logic tx,
	input  logic rx
);

	logic sTick;	// shared tick, one phase for both directions
	logic txValid;	// tx queue not empty, starts a frame
	logic txFull;
	uartCfgPkg::byteT txHead;
	logic txDoneTick;	// tx queue pop
	logic txActive;
	uartBusPkg::rxEventT rxEvent;
	logic rxPush;
	logic rxPop;
	logic rxValid;
	logic rxFull;
	uartCfgPkg::byteT rxHead;

	baudGen i_baudGen (
		.clk   (clk),
		.reset (reset),
		.sTick (sTick)
	);

	//////////////////////////////////////////////////////////////////////
	// transmit path
	byteFifo txFifo (
		.clk      (clk),
		.reset    (reset),
		.push     (txReq.push),
		.pushData (txReq.data),
		.pop      (txDoneTick),
		.popData  (txHead),
		.valid    (txValid),
		.full     (txFull)
	);

	uartTrans i_uartTrans (
		.clk        (clk),
		.reset      (reset),
		.sTick      (sTick),
		.txStart    (txValid),
		.din        (txHead),
		.tx         (tx),
		.txDoneTick (txDoneTick),
		.txActive   (txActive)
	);

	//////////////////////////////////////////////////////////////////////
	// receive path
	uartRecv i_uartRecv (
		.clk     (clk),
		.reset   (reset),
		.sTick   (sTick),
		.rx      (rx),
		.rxEvent (rxEvent)
	);

	byteFifo rxFifo (
		.clk      (clk),
		.reset    (reset),
		.push     (rxPush),
		.pushData (rxEvent.data),
		.pop      (rxPop),
		.popData  (rxHead),
		.valid    (rxValid),
		.full     (rxFull)
	);

	uartHostPort i_uartHostPort (
		.clk           (clk),
		.reset         (reset),
		.txDoneTick    (txDoneTick),
		.rxEvent       (rxEvent),
		.txValid       (txValid),
		.txFull        (txFull),
		.rxValid       (rxValid),
		.rxFull        (rxFull),
		.rxData        (rxHead),
		.txBusy        (txActive),
		.rxCreditGrant (rxCreditGrant),
		.statusRead    (statusRead),
		.rxPush        (rxPush),
		.rxPop         (rxPop),
		.txCreditRet   (txCreditRet),
		.rxResp        (rxResp),
		.status        (status)
	);

endmodule

`default_nettype wire

/* hdl/uartRecv.sv */
/*
 * uart deserializer: two-flop rx sync, idle, start, data, stop FSM
 * mid-bit sampling, stop bit check, one event per frame
 */
`timescale 1ns/1ps
`default_nettype none

module uartRecv (
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	input  logic rx,
	output uartBusPkg::rxEventT rxEvent
);

	typedef enum logic [1:0] {stIdle, stStart, stData, stStop} stateT;

	logic rxMeta;	// first sync flop
	logic rxSync;	// second sync flop, safe to use
	logic rxLast;	// previous synced value, edge detect
	logic rxFall;
	stateT stateReg;
	stateT stateNext;
	uartCfgPkg::tickCntT sReg;
	uartCfgPkg::tickCntT sNext;
	uartCfgPkg::bitCntT nReg;
	uartCfgPkg::bitCntT nNext;
	uartCfgPkg::byteT bReg;	// bits shift in from the top
	uartCfgPkg::byteT bNext;

	//////////////////////////////////////////////////////////////////////
	// input sync, all high at reset like an idle line
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxLast <= 1'b1;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxLast <= rxSync;
		end
	end

	// a real edge, so a line stuck low after a bad stop bit does not restart
	assign rxFall = rxLast & ~rxSync;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= stIdle;
			sReg     <= '0;
			nReg     <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	//////////////////////////////////////////////////////////////////////
	// sampling FSM
	always_comb
	begin
		stateNext        = stateReg;
		sNext            = sReg;
		nNext            = nReg;
		bNext            = bReg;
		rxEvent.valid    = 1'b0;
		rxEvent.frameErr = 1'b0;
		rxEvent.data     = bReg;
		case (stateReg)
			stIdle:
				if (rxFall)
				begin
					sNext     = '0;
					stateNext = stStart;
				end
			stStart:
				if (sTick)
				begin
					if (sReg == uartCfgPkg::midTick)
					begin
						sNext = '0;	// realign to mid-bit
						nNext = '0;
						if (!rxSync)
							stateNext = stData;	// start confirmed
						else
							stateNext = stIdle;	// glitch, no event
					end
					else
						sNext = sReg + 1'b1;
				end
			stData:
				if (sTick)
				begin
					if (sReg == uartCfgPkg::lastTick)
					begin
						sNext = '0;
						bNext = {rxSync, bReg[uartCfgPkg::dataBits-1:1]};	// lsb first
						if (nReg == uartCfgPkg::lastBit)
							stateNext = stStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			stStop:
				if (sTick)
				begin
					if (sReg == uartCfgPkg::stopTick)	// middle of stop bit
					begin
						rxEvent.valid    = 1'b1;
						rxEvent.frameErr = ~rxSync;
						stateNext        = stIdle;
					end
					else
						sNext = sReg + 1'b1;
				end
			default: stateNext = stIdle;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/uartTrans.sv */
/*
 * uart serializer: idle, start, data, stop FSM
 * 16 ticks per bit, lsb first, byte latched as it leaves the queue
 */
`timescale 1ns/1ps
`default_nettype none

module uartTrans (
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	input  logic txStart,
	input  uartCfgPkg::byteT din,
	output logic tx,
	output logic txDoneTick,
	output logic txActive
);

	typedef enum logic [1:0] {stIdle, stStart, stData, stStop} stateT;

	stateT stateReg;
	stateT stateNext;
	uartCfgPkg::tickCntT sReg;	// tick within the bit
	uartCfgPkg::tickCntT sNext;
	uartCfgPkg::bitCntT nReg;	// data bit index
	uartCfgPkg::bitCntT nNext;
	uartCfgPkg::byteT bReg;	// shift register, lsb goes out
	uartCfgPkg::byteT bNext;
	logic txReg;	// registered line value
	logic txNext;

	//////////////////////////////////////////////////////////////////////
	// registers
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= stIdle;
			sReg     <= '0;
			nReg     <= '0;
			txReg    <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			txReg    <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;	// payload

	//////////////////////////////////////////////////////////////////////
	// next state, line value changes on the same edge as the state
	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		txNext     = txReg;
		txDoneTick = 1'b0;
		case (stateReg)
			stIdle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					txDoneTick = 1'b1;	// read strobe for the queue
					bNext      = din;	// grab head before it moves
					sNext      = '0;
					txNext     = 1'b0;	// start bit from next edge
					stateNext  = stStart;
				end
			end
			stStart:
			begin
				if (sTick)
				begin
					if (sReg == uartCfgPkg::lastTick)
					begin
						sNext     = '0;
						nNext     = '0;
						txNext    = bReg[0];	// first data bit
						stateNext = stData;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			stData:
			begin
				if (sTick)
				begin
					if (sReg == uartCfgPkg::lastTick)
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == uartCfgPkg::lastBit)
						begin
							txNext    = 1'b1;	// stop bit
							stateNext = stStop;
						end
						else
						begin
							txNext = bReg[1];	// bit after the shift
							nNext  = nReg + 1'b1;
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			stStop:
			begin
				if (sTick)
				begin
					if (sReg == uartCfgPkg::stopTick)
						stateNext = stIdle;
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = stIdle;
		endcase
	end

	assign tx       = txReg;
	assign txActive = (stateReg != stIdle);	// txBusy in status

	// line carries the value chosen one cycle earlier
	assert property (@(posedge clk) disable iff (reset) 1'b1 |=> (tx == $past(txNext)));
	// queue read strobe only from idle and only with a byte waiting
	assert property (@(posedge clk) disable iff (reset) (stateReg != stIdle) |-> !txDoneTick);
	assert property (@(posedge clk) disable iff (reset) !txStart |-> !txDoneTick);

endmodule

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# Verilator build and run of the uart peripheral testbench
# a failed build or run, or the fail message in the log, gives a nonzero status
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f uartPeriph.f --top-module uartPeriphTb \
	-o uartPeriphSim \
	&& ./obj_dir/uartPeriphSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

/* tb/uartPeriphTb.sv */
/*
 * testbench for the uart peripheral: clock, reset, loopback, directed tests
 * with credit tracking, delivery checks and the final report
 */
`timescale 1ns/1ps
`default_nettype none

module uartPeriphTb;

	localparam int bitCycles     = uartCfgPkg::overSample * uartCfgPkg::baudDivisor;	// 64
	localparam int frameCycles   = 10 * bitCycles;	// 640
	localparam int timeoutCycles = 40000;	// about 45 frames plus margin

	logic clk;
	logic reset;
	uartBusPkg::txReqT txReq;
	logic rxCreditGrant;
	logic statusRead;
	logic txCreditRet;
	uartBusPkg::rxRespT rxResp;
	uartBusPkg::statusWordT status;
	logic tx;
	logic rxLine;
	logic rxBang;	// bit-banged line when loopback is off
	logic loopback;

	integer seed;
	int txCredits;	// host side transmit credits
	int creditRets;
	int cycleCnt;
	int valueErrs;
	int otherErrs;
	uartCfgPkg::byteT expQ[$];	// bytes sent, in order
	uartCfgPkg::byteT gotQ[$];	// bytes delivered on rxResp

	assign rxLine = loopback ? tx : rxBang;

	uartPeriph i_uartPeriph (
		.clk           (clk),
		.reset         (reset),
		.txReq         (txReq),
		.rxCreditGrant (rxCreditGrant),
		.statusRead    (statusRead),
		.txCreditRet   (txCreditRet),
		.rxResp        (rxResp),
		.status        (status),
		.tx            (tx),
		.rx            (rxLine)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	//////////////////////////////////////////////////////////////////////
	// monitor, outputs are registered so negedge sees them settled
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (rxResp.valid)
				gotQ.push_back(rxResp.data);
			if (txCreditRet)
			begin
				creditRets++;
				txCredits++;
				requireTrue(txCredits <= 16, "more transmit credits returned than bytes pushed");
			end
		end
	end

	// run limit
	initial
	begin
		cycleCnt = 0;
		while (cycleCnt < timeoutCycles)
		begin
			@(posedge clk);
			cycleCnt++;
		end
		$display("timeout: run stopped after %0d cycles", cycleCnt);
		reportCounts();
		$display("Simulation FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			valueErrs++;
			$display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
		end
	endtask

	task automatic requireTrue(input logic cond, input string what);
		assert (cond)
		else
		begin
			otherErrs++;
			$display("Error at %0t ns: %s", $time, what);
		end
	endtask

	task automatic reportCounts();
		$display("errors: %0d wrong values, %0d other", valueErrs, otherErrs);
	endtask

	function automatic uartCfgPkg::byteT randByte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// waits for a credit, one push per cycle at most
	task automatic pushByte(input uartCfgPkg::byteT b);
		while (txCredits == 0)
			@(negedge clk);
		txReq.push = 1'b1;
		txReq.data = b;
		txCredits--;
		expQ.push_back(b);
		@(negedge clk);
		txReq.push = 1'b0;
	endtask

	task automatic grantCredits(input int n);
		repeat (n)
		begin
			rxCreditGrant = 1'b1;
			@(negedge clk);
		end
		rxCreditGrant = 1'b0;
	endtask

	task automatic pulseStatusRead();
		statusRead = 1'b1;
		@(negedge clk);
		statusRead = 1'b0;
		@(negedge clk);	// cleared bits visible now
	endtask

	// status lags the push by a few cycles
	task automatic waitTxIdle(input int limit);
		int cnt;
		cnt = 0;
		repeat (4) @(negedge clk);
		while (!(status.txEmpty && !status.txBusy && tx) && cnt < limit)
		begin
			@(negedge clk);
			cnt++;
		end
		requireTrue(cnt < limit, "transmitter did not go idle in time");
		repeat (8) @(negedge clk);	// receiver event and status settle
	endtask

	task automatic waitDeliveries(input int n, input int limit);
		int cnt;
		cnt = 0;
		while (gotQ.size() < n && cnt < limit)
		begin
			@(negedge clk);
			cnt++;
		end
		requireTrue(gotQ.size() >= n, "expected deliveries did not arrive in time");
	endtask

	task automatic matchDeliveries(input int n);
		uartCfgPkg::byteT got;
		uartCfgPkg::byteT exp;
		for (int i = 0; i < n; i++)
		begin
			if (gotQ.size() == 0 || expQ.size() == 0)
			begin
				requireTrue(1'b0, "delivery or expected queue ran empty");
				return;
			end
			got = gotQ.pop_front();
			exp = expQ.pop_front();
			compareValue("rxResp.data", 32'(got), 32'(exp));
		end
	endtask

	// one frame on rx, lsb first
	task automatic sendFrame(input uartCfgPkg::byteT data, input logic stopVal);
		rxBang = 1'b0;
		repeat (bitCycles) @(negedge clk);
		for (int i = 0; i < uartCfgPkg::dataBits; i++)
		begin
			rxBang = data[i];
			repeat (bitCycles) @(negedge clk);
		end
		rxBang = stopVal;
		repeat (bitCycles) @(negedge clk);
		rxBang = 1'b1;
		repeat (bitCycles) @(negedge clk);	// one idle bit
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	task automatic resetStateTest();
		compareValue("tx", 32'(tx), 32'h1);
		compareValue("rxResp.valid", 32'(rxResp.valid), 32'h0);
		compareValue("txCreditRet", 32'(txCreditRet), 32'h0);
		compareValue("status", 32'(status), 32'h05);	// txEmpty, rxEmpty
	endtask

	task automatic singleByteTest();
		creditRets = 0;
		grantCredits(1);
		pushByte(randByte());
		waitDeliveries(1, 2 * frameCycles);
		compareValue("creditRets", 32'(creditRets), 32'd1);
		matchDeliveries(1);
		waitTxIdle(frameCycles);
	endtask

	task automatic burstTest();
		creditRets = 0;
		grantCredits(16);
		repeat (16) pushByte(randByte());
		waitDeliveries(16, 18 * frameCycles);
		compareValue("creditRets", 32'(creditRets), 32'd16);
		matchDeliveries(16);
		waitTxIdle(2 * frameCycles);
	endtask

	task automatic backPressureTest();
		repeat (3) pushByte(randByte());
		repeat (4 * frameCycles) @(negedge clk);
		compareValue("deliveries without credit", 32'(gotQ.size()), 32'd0);
		compareValue("status.rxEmpty", 32'(status.rxEmpty), 32'h0);
		grantCredits(3);
		waitDeliveries(3, 100);
		repeat (32) @(negedge clk);	// room for a stray fourth
		compareValue("delivery count", 32'(gotQ.size()), 32'd3);
		matchDeliveries(3);
	endtask

	task automatic overrunTest();
		repeat (17) pushByte(randByte());
		waitTxIdle(18 * frameCycles);
		compareValue("status.rxFull", 32'(status.rxFull), 32'h1);
		compareValue("status.overrun", 32'(status.overrun), 32'h1);
		compareValue("status.frameErr", 32'(status.frameErr), 32'h0);
		pulseStatusRead();
		compareValue("status.overrun", 32'(status.overrun), 32'h0);
		grantCredits(16);
		waitDeliveries(16, 100);
		repeat (32) @(negedge clk);
		compareValue("delivery count", 32'(gotQ.size()), 32'd16);
		matchDeliveries(16);
		expQ.delete();	// 17th byte was dropped
	endtask

	task automatic framingErrorTest();
		rxBang   = 1'b1;
		loopback = 1'b0;
		grantCredits(1);
		sendFrame(randByte(), 1'b0);	// stop bit low
		repeat (frameCycles) @(negedge clk);
		compareValue("deliveries after bad frame", 32'(gotQ.size()), 32'd0);
		compareValue("status.frameErr", 32'(status.frameErr), 32'h1);
		compareValue("status.overrun", 32'(status.overrun), 32'h0);
		pulseStatusRead();
		compareValue("status.frameErr", 32'(status.frameErr), 32'h0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	initial
	begin
		seed          = 32'h2abe8b2e;
		reset         = 1'b1;
		txReq         = '0;
		rxCreditGrant = 1'b0;
		statusRead    = 1'b0;
		rxBang        = 1'b1;
		loopback      = 1'b1;
		txCredits     = 16;
		creditRets    = 0;
		valueErrs     = 0;
		otherErrs     = 0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		resetStateTest();
		singleByteTest();
		burstTest();
		backPressureTest();
		overrunTest();
		framingErrorTest();

		reportCounts();
		if (valueErrs + otherErrs == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* uartPeriph.f */
hdl/uartCfgPkg.sv
hdl/uartBusPkg.sv
hdl/baudGen.sv
hdl/byteFifo.sv
hdl/uartTrans.sv
hdl/uartRecv.sv
hdl/uartHostPort.sv
hdl/uartPeriph.sv
tb/uartPeriphTb.sv
